// ==== verification/dec_patterns.txt ====
// rnd chk | inst pc rs_val rt_val ready complete exc_flush br_flush mem_rd mem_wa | wren wt_addr aluctr branch dmm_rd exc_happen exc_code sign_imm br_addr j_addr pc_wren hfm
// rnd bits 9..0 randomize the stimulus columns left to right, chk bits 11..0 check the result columns left to right
0c1 fff 00221820 00400000 0 0 1 1 0 0 0 0 1 03 01 0 0 0 00 00001820 00406084 00886080 1 0
0c1 fff 00c72823 00400004 0 0 1 1 0 0 0 0 1 05 04 0 0 0 00 00002823 0040a094 031ca08c 1 0
1c1 fe3 000220c0 0 0 0 1 1 0 0 0 0 1 04 0c 0 0 0 00 0 0 0 1 0
0c1 ffb 2128fffc 00400010 0 0 1 1 0 0 0 0 1 08 01 0 0 0 00 fffffffc 00400004 0 1 0
0c1 ffb 340a8001 00400014 0 0 1 1 0 0 0 0 1 0a 08 0 0 0 00 ffff8001 003e001c 0 1 0
1c1 ff3 3c0b1234 0 0 0 1 1 0 0 0 0 1 0b 0b 0 0 0 00 00001234 0 0 1 0
1c1 ff3 8dac0008 0 0 0 1 1 0 0 0 0 1 0c 01 0 1 0 00 00000008 0 0 1 0
1c1 fff 01817020 0 0 0 1 1 0 0 0 0 0 00 00 0 0 0 00 00000000 00000000 00000000 0 0
0c1 fff 01817020 00400020 0 0 1 1 0 0 0 0 1 0e 01 0 0 0 00 00007020 0041c0a4 0605c080 1 0
1c0 fff 00437820 0 0 0 1 1 0 0 1 03 1 0e 01 0 0 0 00 00007020 0041c0a4 0605c080 0 1
1c0 fe3 00437820 0 0 0 1 1 0 0 1 00 1 0f 01 0 0 0 00 0 0 0 1 0
1c1 fe3 8ca00000 0 0 0 1 1 0 0 0 0 1 00 01 0 1 0 00 0 0 0 1 0
1c1 fe3 00000820 0 0 0 1 1 0 0 0 0 1 01 01 0 0 0 00 0 0 0 1 0
1c1 fe3 8ce60000 0 0 0 1 1 0 0 0 0 1 06 01 0 1 0 00 0 0 0 1 0
1c0 fff 00c64020 0 0 0 1 1 1 0 1 06 0 00 00 0 0 0 00 00000000 00000000 00000000 1 0
0c1 ffb 10220004 00400040 0 0 1 1 0 0 0 0 0 00 00 1 0 0 00 00000004 00400054 0 1 0
1c1 fff 1464ffff 0 0 0 1 1 0 1 0 0 0 00 00 0 0 0 00 00000000 00000000 00000000 1 0
1c1 fe3 014b4826 0 0 0 1 1 0 0 0 0 1 09 09 0 0 0 00 0 0 0 1 0
1c1 fe3 00641027 0 0 0 0 1 0 0 0 0 1 09 09 0 0 0 00 0 0 0 1 0
1c1 fe3 00641027 0 0 0 1 0 0 0 0 0 1 09 09 0 0 0 00 0 0 0 1 0
1c1 fe3 00641027 0 0 0 1 1 0 0 0 0 1 02 0a 0 0 0 00 0 0 0 1 0
0c1 fff 08100010 f0000100 0 0 1 1 0 0 0 0 0 00 00 7 0 0 00 00000010 f0000144 f0400040 1 0
0c1 fff 0fffffff 10000000 0 0 1 1 0 0 0 0 1 1f 00 7 0 0 00 ffffffff 10000000 1ffffffc 1 0
041 fff 00a00008 00400060 12345678 0 1 1 0 0 0 0 0 00 00 7 0 0 00 00000008 00400084 12345678 1 0
0c1 ffb 04910002 00400070 0 0 1 1 0 0 0 0 1 1f 00 3 0 0 00 00000002 0040007c 0 1 0
1c1 fe3 0000000d 0 0 0 1 1 0 0 0 0 0 00 00 0 0 1 09 0 0 0 1 0
1c1 fe3 0000000c 0 0 0 1 1 0 0 0 0 0 00 00 0 0 1 08 0 0 0 1 0
1c1 fe3 fc000000 0 0 0 1 1 0 0 0 0 0 00 00 0 0 1 0a 0 0 0 1 0
1c1 fe3 40026000 0 0 0 1 1 0 0 0 0 0 00 00 0 0 1 0a 0 0 0 1 0
1c1 fe3 90430004 0 0 0 1 1 0 0 0 0 1 03 01 0 1 0 00 0 0 0 1 0

// ==== flist.f ====
+incdir+design
design/dec_pkg.sv
design/inst_decoder.sv
design/target_calc.sv
design/load_use_detect.sv
design/dec_exe_reg.sv
design/dec_stage.sv
verification/dec_stage_tb.sv

// ==== Makefile ====
SIM = obj_dir/Vdec_stage_tb
SRC = $(shell grep -v '^+' flist.f) design/dec_defs.svh

.PHONY: all run clean

all: run

$(SIM): flist.f $(SRC)
	verilator --binary --timing --assert --top-module dec_stage_tb -f flist.f -o Vdec_stage_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1 || true
	cat sim.log
	grep -qx "NO ERRORS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/dec_stage_tb.sv ====
`default_nettype none

`include "dec_defs.svh"

module dec_stage_tb;
    import dec_pkg::*;

    localparam int MAX_LINES = 200;
    localparam int MAX_STEPS = 100;
    localparam int RESET_LIMIT = 20;

    logic                   clk;
    logic                   reset;
    logic [`DATA_W-1:0]     inst;
    logic [`DATA_W-1:0]     pc;
    logic [`DATA_W-1:0]     rs_val;
    logic [`DATA_W-1:0]     rt_val;
    logic                   ready;
    logic                   complete;
    logic                   exception_flush;
    logic                   branch_flush;
    logic                   mem_dmm_read;
    logic [`REG_ADDR_W-1:0] mem_wt_addr;
    logic [`REG_ADDR_W-1:0] rs_addr;
    logic [`REG_ADDR_W-1:0] rt_addr;
    logic                   pc_wren;
    logic                   dec_wren;
    logic                   hazard_flush_mem;
    exe_bundle_t            exe;

    logic [31:0] fld [24];       // one pattern line
    logic [31:0] stim [10];
    logic [31:0] prev_exp [10];  // exe results due at the next edge
    logic [11:0] prev_mask;
    logic        have_prev;
    string       line_buf;
    int          fd;
    int          n_read;
    int          lines_read;
    int          steps;
    int          wait_cycles;

    dec_stage dut_i (
        .clk              (clk),
        .reset            (reset),
        .inst             (inst),
        .pc               (pc),
        .rs_val           (rs_val),
        .rt_val           (rt_val),
        .ready            (ready),
        .complete         (complete),
        .exception_flush  (exception_flush),
        .branch_flush     (branch_flush),
        .mem_dmm_read     (mem_dmm_read),
        .mem_wt_addr      (mem_wt_addr),
        .rs_addr          (rs_addr),
        .rt_addr          (rt_addr),
        .pc_wren          (pc_wren),
        .dec_wren         (dec_wren),
        .hazard_flush_mem (hazard_flush_mem),
        .exe              (exe)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
    end

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_problem(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic check_value(input logic enable, input string name,
                               input logic [31:0] got, input logic [31:0] expected);
        assert (!enable || got === expected)
        else
        begin
            $display("Mismatch at time %0t: %s is %h, expected %h", $time, name, got, expected);
            stop_run();
        end
    endtask

    task automatic check_exe_fields();
        check_value(prev_mask[11], "exe.regfile_wren", 32'(exe.regfile_wren), prev_exp[0]);
        check_value(prev_mask[10], "exe.wt_addr", 32'(exe.wt_addr), prev_exp[1]);
        check_value(prev_mask[9], "exe.aluctr", 32'(exe.aluctr), prev_exp[2]);
        check_value(prev_mask[8], "exe.branch", 32'(exe.branch), prev_exp[3]);
        check_value(prev_mask[7], "exe.dmm_read", 32'(exe.dmm_read), prev_exp[4]);
        check_value(prev_mask[7], "exe.mem2reg", 32'(exe.mem2reg), prev_exp[4]); // loads only
        check_value(prev_mask[6], "exe.exc_happen", 32'(exe.exc_happen), prev_exp[5]);
        check_value(prev_mask[5], "exe.exc_code", 32'(exe.exc_code), prev_exp[6]);
        check_value(prev_mask[4], "exe.sign_imm", exe.sign_imm, prev_exp[7]);
        check_value(prev_mask[3], "exe.branch_address", exe.branch_address, prev_exp[8]);
        check_value(prev_mask[2], "exe.jump_address", exe.jump_address, prev_exp[9]);
    endtask

    task automatic run_step();
        int j;
        @(posedge clk);
        #2;
        if (have_prev)
            check_exe_fields();
        for (j = 0; j < 10; j++)
            stim[j] = fld[0][9-j] ? $urandom : fld[2+j]; // don't-care columns
        inst = stim[0];
        pc = stim[1];
        rs_val = stim[2];
        rt_val = stim[3];
        ready = stim[4][0];
        complete = stim[5][0];
        exception_flush = stim[6][0];
        branch_flush = stim[7][0];
        mem_dmm_read = stim[8][0];
        mem_wt_addr = stim[9][`REG_ADDR_W-1:0];
        #10;
        // rs and rt sit in bits 25:21 and 20:16 of every format
        check_value(1'b1, "rs_addr", 32'(rs_addr), 32'(stim[0][25:21]));
        check_value(1'b1, "rt_addr", 32'(rt_addr), 32'(stim[0][20:16]));
        check_value(fld[1][1], "pc_wren", 32'(pc_wren), fld[22]);
        check_value(fld[1][1], "dec_wren", 32'(dec_wren), fld[22]);
        check_value(fld[1][0], "hazard_flush_mem", 32'(hazard_flush_mem), fld[23]);
        for (j = 0; j < 10; j++)
            prev_exp[j] = fld[12+j];
        prev_mask = fld[1][11:0];
        have_prev = 1'b1;
    endtask

    initial
    begin
        void'($urandom(16));
        inst = '0;
        pc = '0;
        rs_val = '0;
        rt_val = '0;
        ready = 1'b0;
        complete = 1'b0;
        exception_flush = 1'b0;
        branch_flush = 1'b0;
        mem_dmm_read = 1'b0;
        mem_wt_addr = '0;
        have_prev = 1'b0;
        prev_mask = '0;
        lines_read = 0;
        steps = 0;

        wait_cycles = 0;
        while (reset !== 1'b0)
        begin
            @(posedge clk);
            wait_cycles++;
            if (wait_cycles > RESET_LIMIT)
                report_problem("reset did not end within the cycle limit");
        end
        #2;
        check_value(1'b1, "exe.regfile_wren", 32'(exe.regfile_wren), 32'd0);
        check_value(1'b1, "exe.dmm_read", 32'(exe.dmm_read), 32'd0);
        check_value(1'b1, "exe.dmm_write", 32'(exe.dmm_write), 32'd0);
        check_value(1'b1, "exe.branch", 32'(exe.branch), 32'd0);
        check_value(1'b1, "exe.inst_jr", 32'(exe.inst_jr), 32'd0);
        check_value(1'b1, "exe.exc_happen", 32'(exe.exc_happen), 32'd0);
        check_value(1'b1, "exe.wt_addr", 32'(exe.wt_addr), 32'd0);
        check_value(1'b1, "exe.aluctr", 32'(exe.aluctr), 32'd0);
        check_value(1'b1, "exe.lw_sw_type", 32'(exe.lw_sw_type), 32'd0);

        fd = $fopen("verification/dec_patterns.txt", "r");
        if (fd == 0)
            report_problem("could not open the pattern file");
        while (!$feof(fd))
        begin
            lines_read++;
            if (lines_read > MAX_LINES)
                report_problem("pattern file did not end within the line limit");
            n_read = $fgets(line_buf, fd);
            if (n_read > 0)
            begin
                n_read = $sscanf(line_buf,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                    fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14], fld[15],
                    fld[16], fld[17], fld[18], fld[19], fld[20], fld[21], fld[22], fld[23]);
                if (n_read == 24)
                begin
                    steps++;
                    if (steps > MAX_STEPS)
                        report_problem("too many test steps in the pattern file");
                    run_step();
                end
                else if (n_read > 0)
                    report_problem("a pattern line has the wrong number of columns");
            end
        end
        $fclose(fd);
        if (!have_prev)
            report_problem("the pattern file holds no test steps");

        @(posedge clk); // last step's exe result
        #2;
        check_exe_fields();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/dec_stage.sv ====
`default_nettype none

`include "dec_defs.svh"

module dec_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [`DATA_W-1:0]     inst,
    input  logic [`DATA_W-1:0]     pc,
    input  logic [`DATA_W-1:0]     rs_val,
    input  logic [`DATA_W-1:0]     rt_val,
    input  logic                   ready,
    input  logic                   complete,
    input  logic                   exception_flush,
    input  logic                   branch_flush,
    input  logic                   mem_dmm_read,
    input  logic [`REG_ADDR_W-1:0] mem_wt_addr,
    output logic [`REG_ADDR_W-1:0] rs_addr,
    output logic [`REG_ADDR_W-1:0] rt_addr,
    output logic                   pc_wren,
    output logic                   dec_wren,
    output logic                   hazard_flush_mem,
    output dec_pkg::exe_bundle_t   exe
);
    import dec_pkg::*;

    instr_u                 inst_w;
    ctrl_t                  ctrl;
    logic [`EXC_W-1:0]      exc_code;
    logic [`DATA_W-1:0]     sign_imm;
    logic [`DATA_W-1:0]     unsign_imm;
    logic [`DATA_W-1:0]     pcplus4;
    logic [`DATA_W-1:0]     branch_address;
    logic [`DATA_W-1:0]     jump_address;
    logic [`REG_ADDR_W-1:0] wt_addr;
    logic                   stall_front;
    logic                   exe_hold;
    logic                   bubble;
    logic                   advance;
    logic                   flush;
    exe_bundle_t            exe_d;

    assign inst_w = inst;
    assign rs_addr = inst_w.r_fmt.rs;
    assign rt_addr = inst_w.r_fmt.rt;

    inst_decoder decoder_i (
        .inst     (inst_w),
        .ctrl     (ctrl),
        .exc_code (exc_code)
    );

    target_calc target_i (
        .inst           (inst_w),
        .pc             (pc),
        .rs_val         (rs_val),
        .wt_sel         (ctrl.wt_sel),
        .inst_jr        (ctrl.inst_jr),
        .sign_imm       (sign_imm),
        .unsign_imm     (unsign_imm),
        .pcplus4        (pcplus4),
        .branch_address (branch_address),
        .jump_address   (jump_address),
        .wt_addr        (wt_addr)
    );

    // compares against the load already sitting in exe
    load_use_detect hazard_i (
        .rs_addr         (rs_addr),
        .rt_addr         (rt_addr),
        .exe_dmm_read    (exe.dmm_read),
        .exe_wt_addr     (exe.wt_addr),
        .mem_dmm_read    (mem_dmm_read),
        .mem_wt_addr     (mem_wt_addr),
        .exception_flush (exception_flush),
        .stall_front     (stall_front),
        .exe_hold        (exe_hold),
        .bubble          (bubble)
    );

    assign pc_wren = !stall_front;
    assign dec_wren = !stall_front;
    assign hazard_flush_mem = exe_hold;

    assign advance = ready && complete && !exe_hold;
    assign flush = exception_flush || branch_flush || bubble;

    always_comb
    begin
        exe_d.regfile_wren = ctrl.regfile_wren;
        exe_d.wt_addr = wt_addr;
        exe_d.mem2reg = ctrl.mem2reg;
        exe_d.aluctr = ctrl.aluctr;
        exe_d.branch = ctrl.branch;
        exe_d.inst_jr = ctrl.inst_jr;
        exe_d.lw_sw_type = ctrl.lw_sw_type;
        exe_d.dmm_read = ctrl.dmm_read;
        exe_d.dmm_write = ctrl.dmm_write;
        exe_d.rs_val = rs_val;
        exe_d.rt_val = rt_val;
        exe_d.sign_imm = sign_imm;
        exe_d.unsign_imm = unsign_imm;
        exe_d.branch_address = branch_address;
        exe_d.jump_address = jump_address;
        exe_d.pc = pc;
        exe_d.pcplus4 = pcplus4;
        exe_d.exc_happen = ctrl.exc_happen;
        exe_d.exc_code = exc_code;
    end

    dec_exe_reg pipe_i (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .flush   (flush),
        .d       (exe_d),
        .q       (exe)
    );

endmodule

`default_nettype wire

// ==== design/dec_exe_reg.sv ====
`default_nettype none

module dec_exe_reg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 advance,
    input  logic                 flush,
    input  dec_pkg::exe_bundle_t d,
    output dec_pkg::exe_bundle_t q
);
    import dec_pkg::*;

    exe_bundle_t bubble_d;

    // bubble still carries the operands
    always_comb
    begin
        bubble_d = '0;
        bubble_d.rs_val = d.rs_val;
        bubble_d.rt_val = d.rt_val;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            q.regfile_wren <= 1'b0;
            q.wt_addr <= '0;
            q.mem2reg <= 1'b0;
            q.aluctr <= ALU_NONE;
            q.branch <= BR_NONE;
            q.inst_jr <= 1'b0;
            q.lw_sw_type <= MEM_NONE;
            q.dmm_read <= 1'b0;
            q.dmm_write <= 1'b0;
            q.exc_happen <= 1'b0;
            q.exc_code <= '0;
        end
        else if (advance)
        begin
            if (flush)
                q <= bubble_d;
            else
                q <= d;
        end
    end

endmodule

`default_nettype wire

// ==== design/load_use_detect.sv ====
`default_nettype none

`include "dec_defs.svh"

module load_use_detect (
    input  logic [`REG_ADDR_W-1:0] rs_addr,
    input  logic [`REG_ADDR_W-1:0] rt_addr,
    input  logic                   exe_dmm_read,
    input  logic [`REG_ADDR_W-1:0] exe_wt_addr,
    input  logic                   mem_dmm_read,
    input  logic [`REG_ADDR_W-1:0] mem_wt_addr,
    input  logic                   exception_flush,
    output logic                   stall_front,
    output logic                   exe_hold,
    output logic                   bubble
);
    logic exe_match;
    logic mem_match;
    logic exe_hazard;
    logic mem_hazard;

    // r0 is never a real destination
    assign exe_match = (exe_wt_addr != '0) &&
                       ((exe_wt_addr == rs_addr) || (exe_wt_addr == rt_addr));
    assign mem_match = (mem_wt_addr != '0) &&
                       ((mem_wt_addr == rs_addr) || (mem_wt_addr == rt_addr));

    assign exe_hazard = !exception_flush && exe_dmm_read && exe_match;
    assign mem_hazard = !exception_flush && mem_dmm_read && mem_match;

    assign stall_front = exe_hazard || mem_hazard;
    assign exe_hold = mem_hazard; // load data not back yet
    assign bubble = exe_hazard;

endmodule

`default_nettype wire

// ==== design/target_calc.sv ====
`default_nettype none

`include "dec_defs.svh"

module target_calc (
    input  dec_pkg::instr_u         inst,
    input  logic [`DATA_W-1:0]      pc,
    input  logic [`DATA_W-1:0]      rs_val,
    input  dec_pkg::wt_sel_e        wt_sel,
    input  logic                    inst_jr,
    output logic [`DATA_W-1:0]      sign_imm,
    output logic [`DATA_W-1:0]      unsign_imm,
    output logic [`DATA_W-1:0]      pcplus4,
    output logic [`DATA_W-1:0]      branch_address,
    output logic [`DATA_W-1:0]      jump_address,
    output logic [`REG_ADDR_W-1:0]  wt_addr
);
    import dec_pkg::*;

    assign pcplus4 = pc + `DATA_W'(4);
    assign sign_imm = {{(`DATA_W-16){inst.i_fmt.imm[15]}}, inst.i_fmt.imm};
    assign unsign_imm = {{(`DATA_W-16){1'b0}}, inst.i_fmt.imm};

    assign branch_address = pcplus4 + {sign_imm[`DATA_W-3:0], 2'b00}; // word offset
    assign jump_address = inst_jr ? rs_val
                        : {pcplus4[`DATA_W-1:`DATA_W-4], inst.j_fmt.index, 2'b00};

    always_comb
    begin
        case (wt_sel)
            WT_RT: wt_addr = inst.i_fmt.rt;
            WT_RD: wt_addr = inst.r_fmt.rd;
            WT_LINK: wt_addr = `REG_ADDR_W'(`LINK_REG);
            default: wt_addr = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/inst_decoder.sv ====
`default_nettype none

`include "dec_defs.svh"

module inst_decoder (
    input  dec_pkg::instr_u  inst,
    output dec_pkg::ctrl_t   ctrl,
    output logic [`EXC_W-1:0] exc_code
);
    import dec_pkg::*;

    logic rs_zero;
    logic rt_zero;
    logic rd_zero;
    logic shamt_zero;
    logic valid;

    function automatic ctrl_t alu_ctrl(alu_op_e op, wt_sel_e sel);
        ctrl_t c;
        c = '0;
        c.regfile_wren = 1'b1;
        c.aluctr = op;
        c.wt_sel = sel;
        return c;
    endfunction

    function automatic ctrl_t mem_ctrl(mem_type_e t, logic load);
        ctrl_t c;
        c = '0;
        c.aluctr = ALU_ADD; // address = rs + imm
        c.lw_sw_type = t;
        c.dmm_read = load;
        c.dmm_write = !load;
        c.mem2reg = load;
        c.regfile_wren = load;
        if (load)
            c.wt_sel = WT_RT;
        return c;
    endfunction

    function automatic ctrl_t br_ctrl(branch_e b, logic lnk, logic jr);
        ctrl_t c;
        c = '0;
        c.branch = b;
        c.link = lnk;
        c.inst_jr = jr;
        return c;
    endfunction

    assign rs_zero = (inst.r_fmt.rs == '0);
    assign rt_zero = (inst.r_fmt.rt == '0);
    assign rd_zero = (inst.r_fmt.rd == '0);
    assign shamt_zero = (inst.r_fmt.shamt == '0);

    always_comb
    begin
        ctrl = '0;
        exc_code = '0;
        valid = 1'b1;
        case (inst.r_fmt.opcode)
            6'h00:
            begin
                valid = shamt_zero; // most R-format words need shamt 0
                case (inst.r_fmt.funct)
                    6'h00:
                    begin
                        ctrl = alu_ctrl(ALU_SLL, WT_RD);
                        valid = rs_zero;
                    end
                    6'h02:
                    begin
                        ctrl = alu_ctrl(ALU_SRL, WT_RD);
                        valid = rs_zero;
                    end
                    6'h03:
                    begin
                        ctrl = alu_ctrl(ALU_SRA, WT_RD);
                        valid = rs_zero;
                    end
                    6'h04: ctrl = alu_ctrl(ALU_SLLV, WT_RD);
                    6'h06: ctrl = alu_ctrl(ALU_SRLV, WT_RD);
                    6'h07: ctrl = alu_ctrl(ALU_SRAV, WT_RD);
                    6'h08:
                    begin
                        ctrl = br_ctrl(BR_JUMP, 1'b0, 1'b1); // jr
                        valid = rt_zero && rd_zero && shamt_zero;
                    end
                    6'h09:
                    begin
                        ctrl = br_ctrl(BR_JUMP, 1'b1, 1'b1); // jalr
                        valid = rt_zero && shamt_zero;
                    end
                    6'h0c:
                    begin
                        exc_code = `EXC_W'(`EXC_SYS);
                        valid = 1'b1; // code field is free
                    end
                    6'h0d:
                    begin
                        exc_code = `EXC_W'(`EXC_BP);
                        valid = 1'b1;
                    end
                    6'h20: ctrl = alu_ctrl(ALU_ADD, WT_RD);
                    6'h21: ctrl = alu_ctrl(ALU_ADDU, WT_RD);
                    6'h22: ctrl = alu_ctrl(ALU_SUB, WT_RD);
                    6'h23: ctrl = alu_ctrl(ALU_SUBU, WT_RD);
                    6'h24: ctrl = alu_ctrl(ALU_AND, WT_RD);
                    6'h25: ctrl = alu_ctrl(ALU_OR, WT_RD);
                    6'h26: ctrl = alu_ctrl(ALU_XOR, WT_RD);
                    6'h27: ctrl = alu_ctrl(ALU_NOR, WT_RD);
                    6'h2a: ctrl = alu_ctrl(ALU_SLT, WT_RD);
                    6'h2b: ctrl = alu_ctrl(ALU_SLTU, WT_RD);
                    default: valid = 1'b0;
                endcase
            end
            6'h01:
            begin
                case (inst.i_fmt.rt) // REGIMM selects on rt
                    5'b00000: ctrl = br_ctrl(BR_LTZ, 1'b0, 1'b0);
                    5'b00001: ctrl = br_ctrl(BR_GEZ, 1'b0, 1'b0);
                    5'b10000: ctrl = br_ctrl(BR_LTZ, 1'b1, 1'b0);
                    5'b10001: ctrl = br_ctrl(BR_GEZ, 1'b1, 1'b0);
                    default: valid = 1'b0;
                endcase
            end
            6'h02: ctrl = br_ctrl(BR_JUMP, 1'b0, 1'b0);
            6'h03: ctrl = br_ctrl(BR_JUMP, 1'b1, 1'b0);
            6'h04: ctrl = br_ctrl(BR_EQ, 1'b0, 1'b0);
            6'h05: ctrl = br_ctrl(BR_NE, 1'b0, 1'b0);
            6'h06:
            begin
                ctrl = br_ctrl(BR_LEZ, 1'b0, 1'b0);
                valid = rt_zero;
            end
            6'h07:
            begin
                ctrl = br_ctrl(BR_GTZ, 1'b0, 1'b0);
                valid = rt_zero;
            end
            6'h08: ctrl = alu_ctrl(ALU_ADD, WT_RT);
            6'h09: ctrl = alu_ctrl(ALU_ADDU, WT_RT);
            6'h0a: ctrl = alu_ctrl(ALU_SLT, WT_RT);
            6'h0b: ctrl = alu_ctrl(ALU_SLTU, WT_RT);
            6'h0c: ctrl = alu_ctrl(ALU_AND, WT_RT); // zero-extended imm
            6'h0d: ctrl = alu_ctrl(ALU_OR, WT_RT);
            6'h0e: ctrl = alu_ctrl(ALU_XOR, WT_RT);
            6'h0f:
            begin
                ctrl = alu_ctrl(ALU_LUI, WT_RT);
                valid = rs_zero;
            end
            6'h20: ctrl = mem_ctrl(MEM_B, 1'b1);
            6'h21: ctrl = mem_ctrl(MEM_H, 1'b1);
            6'h23: ctrl = mem_ctrl(MEM_W, 1'b1);
            6'h24: ctrl = mem_ctrl(MEM_BU, 1'b1);
            6'h25: ctrl = mem_ctrl(MEM_HU, 1'b1);
            6'h28: ctrl = mem_ctrl(MEM_B, 1'b0);
            6'h29: ctrl = mem_ctrl(MEM_H, 1'b0);
            6'h2b: ctrl = mem_ctrl(MEM_W, 1'b0);
            default: valid = 1'b0; // cop0, cache and the rest
        endcase

        if (ctrl.link)
        begin
            ctrl.regfile_wren = 1'b1;
            ctrl.wt_sel = WT_LINK;
        end

        if (!valid)
        begin
            ctrl = '0;
            exc_code = `EXC_W'(`EXC_RI);
        end
        ctrl.exc_happen = (exc_code != '0);
    end

endmodule

`default_nettype wire

// ==== design/dec_pkg.sv ====
`default_nettype none

`include "dec_defs.svh"

package dec_pkg;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        logic [5:0]             funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]             opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } i_fmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_fmt_t;

    // one instruction word, three views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef enum logic [4:0] {
        ALU_NONE, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE, BR_EQ, BR_NE, BR_GEZ, BR_GTZ, BR_LEZ, BR_LTZ, BR_JUMP
    } branch_e;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_B, MEM_BU, MEM_H, MEM_HU, MEM_W
    } mem_type_e;

    typedef enum logic [1:0] {
        WT_NONE, WT_RT, WT_RD, WT_LINK
    } wt_sel_e;

    typedef struct packed {
        logic      regfile_wren;
        logic      mem2reg;
        alu_op_e   aluctr;
        wt_sel_e   wt_sel;
        branch_e   branch;
        logic      inst_jr;
        mem_type_e lw_sw_type;
        logic      dmm_read;
        logic      dmm_write;
        logic      exc_happen;
        logic      link;
    } ctrl_t;

    typedef struct packed {
        logic                   regfile_wren;
        logic [`REG_ADDR_W-1:0] wt_addr;
        logic                   mem2reg;
        alu_op_e                aluctr;
        branch_e                branch;
        logic                   inst_jr;
        mem_type_e              lw_sw_type;
        logic                   dmm_read;
        logic                   dmm_write;
        logic [`DATA_W-1:0]     rs_val;
        logic [`DATA_W-1:0]     rt_val;
        logic [`DATA_W-1:0]     sign_imm;
        logic [`DATA_W-1:0]     unsign_imm;
        logic [`DATA_W-1:0]     branch_address;
        logic [`DATA_W-1:0]     jump_address;
        logic [`DATA_W-1:0]     pc;
        logic [`DATA_W-1:0]     pcplus4;
        logic                   exc_happen;
        logic [`EXC_W-1:0]      exc_code;
    } exe_bundle_t;

endpackage

`default_nettype wire

// ==== design/dec_defs.svh ====
`ifndef DEC_DEFS_SVH
`define DEC_DEFS_SVH

// datapath and register file widths
`define DATA_W      32
`define REG_ADDR_W  5

// return address register for jal, jalr and the link branches
`define LINK_REG    31

// exception codes raised by decode
`define EXC_W       5
`define EXC_SYS     8
`define EXC_BP      9
`define EXC_RI      10

`endif
